//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = tbDrawUnit
FILELIST = tb.f
OBJDIR = obj_dir
LOG = sim.log
PASS_MSG = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(wildcard *.sv) $(wildcard *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- cmdQueue.sv
`include "draw_params.svh"

module cmdQueue
(
	input logic clk,
	input logic rst,
	input logic we, // Host write strobe
	input drawPkg::cmdWordT data, // Host command word
	input logic pop, // From painter, one word per strobe
	output drawPkg::cmdWordT rdData, // Word at rdPtr, registered
	output drawPkg::queueCountT count, // Words held
	output logic full
);

	localparam int depth = 2 ** `QUEUE_AW;

	drawPkg::cmdWordT mem [0:depth-1]; // Block memory, circular
	drawPkg::queuePtrT wrPtr; // Next slot the host fills
	drawPkg::queuePtrT rdPtr; // Oldest unread word
	logic accept; // Host word actually stored

	// One slot stays empty so wrPtr never laps rdPtr
	assign full = (count == drawPkg::queueCountT'(depth - 1));
	assign accept = we && !full; // Words offered while full are lost

	////////////////////
	// Storage
	////////////////////
	always_ff @(posedge clk)
	begin
		if (accept)
			mem[wrPtr] <= data;
		rdData <= mem[rdPtr]; // Valid one clock after rdPtr settles
	end

	////////////////////
	// Pointers and level
	////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (accept)
				wrPtr <= wrPtr + 1'b1; // Wraps at depth
			if (pop)
				rdPtr <= rdPtr + 1'b1;

			case ({accept, pop})
				2'b10: count <= count + 1'b1; // Write only
				2'b01: count <= count - 1'b1; // Pop only
				default: count <= count; // Both or neither
			endcase
		end
	end

endmodule

//--- drawPkg.sv
package drawPkg;

`include "draw_params.svh"

	////////////////////
	// Datapath widths
	////////////////////
	typedef logic [15:0] cmdWordT; // Host command word
	typedef logic [2:0] colorT; // {R,G,B}
	typedef logic [7:0] coordXT; // Span end, may exceed frame width
	typedef logic [6:0] lineT; // Line number from word A
	typedef logic [14:0] pixelAddrT; // line * FRAME_W + x

	// Queue bookkeeping
	typedef logic [`QUEUE_AW-1:0] queuePtrT;
	typedef logic [`QUEUE_AW:0] queueCountT; // One extra bit so 0..64 fits

	// Raster counters
	typedef logic [7:0] hCountT; // 0..191
	typedef logic [7:0] vCountT; // 0..127

	////////////////////
	// Painter FSM
	////////////////////
	typedef enum logic [1:0]
	{
		idle, // Waiting for a full command pair
		fetchA, // Word A taken, read pointer moving to B
		fetchB, // Word B on rdData
		draw // One pixel per clock
	} painterStateT;

endpackage

//--- drawUnit.sv
module drawUnit
(
	input logic clk,
	input logic rst,
	input logic we, // Host command write
	input drawPkg::cmdWordT data,
	output logic full,
	output logic busy, // Queue or painter still working
	output drawPkg::colorT color, // {R,G,B}
	output logic hsync,
	output logic vsync
);

	// Queue to painter
	drawPkg::queueCountT count;
	drawPkg::cmdWordT rdData;
	logic pop;

	// Painter to frame store
	logic pixelWe;
	drawPkg::pixelAddrT pixelAddr;
	drawPkg::colorT pixelColor;

	// Scan-out read path
	drawPkg::pixelAddrT rdAddr;
	drawPkg::colorT rdColor;

	cmdQueue i_cmdQueue
	(
		.clk(clk),
		.rst(rst),
		.we(we),
		.data(data),
		.pop(pop),
		.rdData(rdData),
		.count(count),
		.full(full)
	);

	spanPainter i_spanPainter
	(
		.clk(clk),
		.rst(rst),
		.count(count),
		.rdData(rdData),
		.pop(pop),
		.pixelWe(pixelWe),
		.pixelAddr(pixelAddr),
		.pixelColor(pixelColor),
		.busy(busy)
	);

	frameStore i_frameStore
	(
		.clk(clk),
		.pixelWe(pixelWe),
		.pixelAddr(pixelAddr),
		.pixelColor(pixelColor),
		.rdAddr(rdAddr),
		.rdColor(rdColor)
	);

	rasterScan i_rasterScan
	(
		.clk(clk),
		.rst(rst),
		.rdAddr(rdAddr),
		.rdColor(rdColor),
		.color(color),
		.hsync(hsync),
		.vsync(vsync)
	);

endmodule

//--- draw_params.svh
`ifndef DRAW_PARAMS_SVH
`define DRAW_PARAMS_SVH

////////////////////
// Frame format
////////////////////
`define FRAME_W 160 // Pixels per line
`define FRAME_H 120 // Lines per frame

// Lines 0..114 live in the main buffer, 115..119 in the special buffer
`define MAIN_LINES 115
`define SPECIAL_BASE 18400 // MAIN_LINES * FRAME_W

////////////////////
// Scaled raster, one pixel per clk
////////////////////
`define H_FP 8 // Clocks
`define H_SYNC 16
`define H_BP 8
`define V_FP 2 // Lines
`define V_SYNC 4
`define V_BP 2

`define QUEUE_AW 6 // 64 command words

`endif

//--- frameStore.sv
`include "draw_params.svh"

module frameStore
(
	input logic clk,
	input logic pixelWe, // Painter write port
	input drawPkg::pixelAddrT pixelAddr,
	input drawPkg::colorT pixelColor,
	input drawPkg::pixelAddrT rdAddr, // Scan-out read port
	output drawPkg::colorT rdColor // One clock after rdAddr
);

	localparam int mainSize = `SPECIAL_BASE; // Lines 0..114
	localparam int specialSize = (`FRAME_H - `MAIN_LINES) * `FRAME_W; // Lines 115..119

	drawPkg::colorT memMain [0:mainSize-1];
	drawPkg::colorT memSpecial [0:specialSize-1];

	drawPkg::pixelAddrT wrOffset; // Write address inside special buffer
	drawPkg::pixelAddrT rdOffset; // Read address inside special buffer
	logic wrSpecial;
	logic rdSpecial;

	drawPkg::colorT mainQ; // Registered read data
	drawPkg::colorT specialQ;
	logic selSpecial; // Buffer chosen by the registered address

	// Both buffers come up black
	initial
	begin
		for (int i = 0; i < mainSize; i++)
			memMain[i] = '0;
		for (int i = 0; i < specialSize; i++)
			memSpecial[i] = '0;
	end

	////////////////////
	// Address split
	////////////////////
	assign wrSpecial = (pixelAddr >= drawPkg::pixelAddrT'(`SPECIAL_BASE));
	assign rdSpecial = (rdAddr >= drawPkg::pixelAddrT'(`SPECIAL_BASE));
	assign wrOffset = pixelAddr - drawPkg::pixelAddrT'(`SPECIAL_BASE);
	assign rdOffset = rdAddr - drawPkg::pixelAddrT'(`SPECIAL_BASE);

	// Write routing, takes effect on this edge
	always_ff @(posedge clk)
	begin
		if (pixelWe && wrSpecial)
			memSpecial[wrOffset[9:0]] <= pixelColor;
		if (pixelWe && !wrSpecial)
			memMain[pixelAddr] <= pixelColor;
	end

	////////////////////
	// Read side
	////////////////////
	always_ff @(posedge clk)
	begin
		mainQ <= memMain[rdAddr]; // Only meaningful below SPECIAL_BASE
		specialQ <= memSpecial[rdOffset[9:0]]; // Only meaningful at or above
		selSpecial <= rdSpecial;
	end

	assign rdColor = selSpecial ? specialQ : mainQ;

endmodule

//--- rasterScan.sv
`include "draw_params.svh"

module rasterScan
(
	input logic clk,
	input logic rst,
	output drawPkg::pixelAddrT rdAddr, // To frame store
	input drawPkg::colorT rdColor, // Back one clock later
	output drawPkg::colorT color, // Blanked pixel
	output logic hsync, // Active low
	output logic vsync // Active low
);

	// Horizontal timeline: active, front porch, sync, back porch
	localparam drawPkg::hCountT hActiveEnd = drawPkg::hCountT'(`FRAME_W);
	localparam drawPkg::hCountT hSyncStart = drawPkg::hCountT'(`FRAME_W + `H_FP);
	localparam drawPkg::hCountT hSyncEnd = drawPkg::hCountT'(`FRAME_W + `H_FP + `H_SYNC);
	localparam drawPkg::hCountT hLast =
		drawPkg::hCountT'(`FRAME_W + `H_FP + `H_SYNC + `H_BP - 1); // 191

	// Vertical timeline, in lines
	localparam drawPkg::vCountT vActiveEnd = drawPkg::vCountT'(`FRAME_H);
	localparam drawPkg::vCountT vSyncStart = drawPkg::vCountT'(`FRAME_H + `V_FP);
	localparam drawPkg::vCountT vSyncEnd = drawPkg::vCountT'(`FRAME_H + `V_FP + `V_SYNC);
	localparam drawPkg::vCountT vLast =
		drawPkg::vCountT'(`FRAME_H + `V_FP + `V_SYNC + `V_BP - 1); // 127

	drawPkg::hCountT hCount;
	drawPkg::vCountT vCount;
	drawPkg::pixelAddrT addrReg; // Linear address of the current active pixel

	logic active; // Counters inside the visible area
	logic lastActive; // Bottom right pixel
	logic hsNow; // Syncs for the current counter position
	logic vsNow;

	logic activeD; // Aligned with rdColor
	logic hsD;
	logic vsD;

	assign active = (hCount < hActiveEnd) && (vCount < vActiveEnd);
	assign lastActive = (hCount == hActiveEnd - 1'b1) && (vCount == vActiveEnd - 1'b1);
	assign hsNow = !((hCount >= hSyncStart) && (hCount < hSyncEnd));
	assign vsNow = !((vCount >= vSyncStart) && (vCount < vSyncEnd)); // Steps at line start
	assign rdAddr = addrReg;

	////////////////////
	// Raster counters
	////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			hCount <= '0;
			vCount <= '0;
			addrReg <= '0;
		end
		else
		begin
			if (hCount == hLast)
			begin
				hCount <= '0;
				if (vCount == vLast)
					vCount <= '0; // New frame
				else
					vCount <= vCount + 1'b1;
			end
			else
				hCount <= hCount + 1'b1;

			// Active pixels are contiguous in linear order
			if (lastActive)
				addrReg <= '0; // Ready for next frame, stays in range in blanking
			else if (active)
				addrReg <= addrReg + 1'b1;
		end
	end

	////////////////////
	// Output pipeline
	////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			activeD <= 1'b0;
			hsD <= 1'b1;
			vsD <= 1'b1;
			color <= '0;
			hsync <= 1'b1;
			vsync <= 1'b1;
		end
		else
		begin
			// Match the frame store read latency
			activeD <= active;
			hsD <= hsNow;
			vsD <= vsNow;

			// Colour and syncs leave together
			color <= activeD ? rdColor : '0;
			hsync <= hsD;
			vsync <= vsD;
		end
	end

endmodule

//--- spanPainter.sv
`include "draw_params.svh"

module spanPainter
(
	input logic clk,
	input logic rst,
	input drawPkg::queueCountT count, // Queue level
	input drawPkg::cmdWordT rdData, // Registered queue output
	output logic pop,
	output logic pixelWe,
	output drawPkg::pixelAddrT pixelAddr,
	output drawPkg::colorT pixelColor,
	output logic busy
);

	drawPkg::painterStateT state;

	// Command held while drawing
	drawPkg::lineT lineReg; // From word A, bits 14:8
	drawPkg::colorT colorReg; // From word A, bits 2:0
	drawPkg::coordXT curX; // Pixel being written
	drawPkg::coordXT endX; // Last pixel of the clipped span
	drawPkg::pixelAddrT addrReg; // Running address of curX

	// Word B decode
	drawPkg::coordXT left;
	drawPkg::coordXT right;
	drawPkg::coordXT spanLo; // Ordered ends
	drawPkg::coordXT spanHi;
	drawPkg::coordXT spanEnd; // spanHi clipped to the last column

	logic start; // Command pair available in idle
	logic lineOk; // Line inside the frame
	logic spanOk; // At least one pixel on screen
	logic popWait; // rdData still on word B one clock after pop B

	////////////////////
	// Decode
	////////////////////
	assign left = rdData[15:8];
	assign right = rdData[7:0];
	assign spanLo = (left < right) ? left : right; // Either order allowed
	assign spanHi = (left < right) ? right : left;
	assign spanEnd = (spanHi > drawPkg::coordXT'(`FRAME_W - 1)) ?
		drawPkg::coordXT'(`FRAME_W - 1) : spanHi;

	assign lineOk = (lineReg < drawPkg::lineT'(`FRAME_H));
	assign spanOk = (spanLo < drawPkg::coordXT'(`FRAME_W)); // Fully off-screen span draws nothing

	// Never start on a lone word, both halves must be queued
	assign start = (state == drawPkg::idle) && (count >= drawPkg::queueCountT'(2)) && !popWait;

	////////////////////
	// Outputs
	////////////////////
	assign pop = start || (state == drawPkg::fetchB); // Pop A, then B two clocks later
	assign pixelWe = (state == drawPkg::draw);
	assign pixelAddr = addrReg;
	assign pixelColor = colorReg;
	assign busy = (count != '0) || (state != drawPkg::idle);

	////////////////////
	// FSM
	////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= drawPkg::idle;
			popWait <= 1'b0;
		end
		else
		begin
			popWait <= (state == drawPkg::fetchB); // Skipped command returns to idle early
			case (state)
				drawPkg::idle:
				begin
					if (start)
						state <= drawPkg::fetchA;
				end
				drawPkg::fetchA: state <= drawPkg::fetchB; // rdData moving to word B
				drawPkg::fetchB:
				begin
					// Bad line or empty span, command consumed anyway
					if (lineOk && spanOk)
						state <= drawPkg::draw;
					else
						state <= drawPkg::idle;
				end
				drawPkg::draw:
				begin
					if (curX == endX)
						state <= drawPkg::idle; // Last pixel this clock
				end
				default: state <= drawPkg::idle;
			endcase
		end
	end

	////////////////////
	// Span datapath
	////////////////////
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			// Word A already on rdData since the pointer is stable in idle
			lineReg <= rdData[14:8];
			colorReg <= rdData[2:0];
		end

		if (state == drawPkg::fetchB)
		begin
			curX <= spanLo;
			endX <= spanEnd;
			addrReg <= drawPkg::pixelAddrT'(lineReg) * drawPkg::pixelAddrT'(`FRAME_W)
				+ drawPkg::pixelAddrT'(spanLo); // Row base plus start column
		end
		else if (state == drawPkg::draw)
		begin
			curX <= curX + 1'b1; // Ascending order
			addrReg <= addrReg + 1'b1;
		end
	end

endmodule

//--- tb.f
+incdir+.
drawPkg.sv
cmdQueue.sv
spanPainter.sv
frameStore.sv
rasterScan.sv
drawUnit.sv
tbDrawUnit.sv

//--- tbDrawUnit.sv
`include "draw_params.svh"

module tbDrawUnit;

	localparam int lineClocks = `FRAME_W + `H_FP + `H_SYNC + `H_BP; // 192
	localparam int frameLines = `FRAME_H + `V_FP + `V_SYNC + `V_BP; // 128
	localparam int frameClocks = lineClocks * frameLines;
	localparam int timeoutCycles = 8 * frameClocks; // Four clean frames, up to two frames each

	logic clk = 1'b0;
	logic rst;
	logic we;
	drawPkg::cmdWordT data;
	logic full;
	logic busy;
	drawPkg::colorT color;
	logic hsync;
	logic vsync;

	logic [31:0] lfsr = 32'hc96afa74;
	drawPkg::colorT model [0:`FRAME_H-1][0:`FRAME_W-1]; // Expected frame

	// Scan checker state
	int hPos; // Clocks since hsync rose
	int vLine; // Line number, negative in back porch
	int x;
	int y;
	int hsLow;
	int vsLow;
	int sampleNo;
	int lastFall;
	logic hSynced;
	logic vSynced;
	logic hsFallSeen;
	logic hsPrev;
	logic vsPrev;
	logic active;
	logic frameOn; // Frame compared against model
	logic settled = 1'b0; // Stimulus quiet, DUT may be compared
	int framesDone = 0;
	int pixelChecks = 0;
	int syncChecks = 0;
	int scanErrors = 0;
	int ctrlErrors = 0;
	int cycles = 0;

	drawUnit i_dut
	(
		.clk(clk),
		.rst(rst),
		.we(we),
		.data(data),
		.full(full),
		.busy(busy),
		.color(color),
		.hsync(hsync),
		.vsync(vsync)
	);

	always #4 clk = ~clk;

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [15:0] randBits(input int n);
		logic [15:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[14:0], fb};
		end
		return r;
	endfunction

	// Span rules applied to the expected frame
	task automatic paintModel(input drawPkg::cmdWordT wordA, input drawPkg::cmdWordT wordB);
		int line;
		int lo;
		int hi;
		int t;
		line = int'(wordA[14:8]);
		lo = int'(wordB[15:8]);
		hi = int'(wordB[7:0]);
		if (lo > hi)
		begin
			t = lo; // Ends in either order
			lo = hi;
			hi = t;
		end
		if (hi > `FRAME_W - 1)
			hi = `FRAME_W - 1; // Clip at right edge
		if (line < `FRAME_H)
			for (int i = lo; i <= hi; i++)
				model[line][i] = wordA[2:0];
	endtask

	task automatic sendWord(input drawPkg::cmdWordT w);
		@(negedge clk);
		while (full)
		begin
			we = 1'b0; // Hold off while queue is full
			@(negedge clk);
		end
		we = 1'b1;
		data = w;
	endtask

	// Let the painter drain, then see one whole frame compared
	task automatic waitCleanFrame();
		int startCount;
		@(negedge clk);
		we = 1'b0;
		while (busy)
			@(negedge clk);
		startCount = framesDone;
		settled <= 1'b1;
		while (framesDone == startCount)
			@(negedge clk);
		settled <= 1'b0;
	endtask

	////////////////////
	// Scan-out checker
	////////////////////
	always @(negedge clk)
	begin
		if (rst)
		begin
			hSynced = 1'b0;
			vSynced = 1'b0;
			hsFallSeen = 1'b0;
			hsPrev = 1'b1;
			vsPrev = 1'b1;
			hsLow = 0;
			vsLow = 0;
			frameOn = 1'b0;
		end
		else
		begin
			sampleNo++;
			if (!hsync && hsPrev)
			begin
				if (hsFallSeen)
				begin
					assert (sampleNo - lastFall == lineClocks) else
					begin
						$display("Fail %0t: hsync period %0d clocks", $time, sampleNo - lastFall);
						scanErrors++;
					end
					syncChecks++;
				end
				hsFallSeen = 1'b1;
				lastFall = sampleNo;
			end
			if (!hsync)
				hsLow++;
			if (!vsync)
				vsLow++;

			if (hsync && !hsPrev) // Back porch starts
			begin
				assert (hsLow == `H_SYNC) else
				begin
					$display("Fail %0t: hsync low for %0d clocks", $time, hsLow);
					scanErrors++;
				end
				hsLow = 0;
				hPos = 0;
				hSynced = 1'b1;
			end
			else
				hPos++;

			if (vsync && !vsPrev)
			begin
				assert (vsLow == `V_SYNC * lineClocks) else
				begin
					$display("Fail %0t: vsync low for %0d clocks", $time, vsLow);
					scanErrors++;
				end
				syncChecks++;
				vsLow = 0;
			end

			// Line number steps at x = 0
			if (hSynced && hPos == `H_BP)
			begin
				if (vsync && !vsPrev)
				begin
					vLine = -`V_BP;
					vSynced = 1'b1;
				end
				else
					vLine++;
				if (vSynced && vLine == 0)
					frameOn = settled && !busy; // Frame drawn after painting ended
			end

			x = hPos - `H_BP;
			y = vLine;
			active = hSynced && vSynced && x >= 0 && x < `FRAME_W && y >= 0 && y < `FRAME_H;
			if (active && frameOn)
			begin
				assert (color == model[y][x]) else
				begin
					$display("Fail %0t: pixel (%0d,%0d) is %0d, expected %0d",
						$time, x, y, color, model[y][x]);
					scanErrors++;
				end
				pixelChecks++;
				if (x == `FRAME_W - 1 && y == `FRAME_H - 1)
				begin
					framesDone <= framesDone + 1;
					frameOn = 1'b0;
				end
			end
			else if (hSynced && vSynced && !active)
			begin
				assert (color == '0) else
				begin
					$display("Fail %0t: color %0d in blanking", $time, color);
					scanErrors++;
				end
			end
			hsPrev = hsync;
			vsPrev = vsync;
		end
	end

	// Run limit
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles == timeoutCycles)
		begin
			$display("Timeout after %0d cycles, DUT never went idle or frames stopped", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	////////////////////
	// Stimulus
	////////////////////
	initial
	begin
		drawPkg::cmdWordT wordA;
		drawPkg::cmdWordT wordB;
		drawPkg::cmdWordT word;
		drawPkg::cmdWordT accepted [$]; // Burst words the queue took
		int line;
		int lo;
		int hi;
		int dropped;
		logic sawFull;

		rst = 1'b1;
		we = 1'b0;
		data = '0;
		for (int r = 0; r < `FRAME_H; r++)
			for (int c = 0; c < `FRAME_W; c++)
				model[r][c] = '0; // Memories start black
		repeat (5) @(negedge clk);
		rst = 1'b0;

		assert (!full && !busy && hsync && vsync) else
		begin
			$display("Fail %0t: reset state full=%b busy=%b hsync=%b vsync=%b",
				$time, full, busy, hsync, vsync);
			ctrlErrors++;
		end
		waitCleanFrame(); // Blank frame

		// Random spans, some reversed, clipped or in the special buffer
		for (int i = 0; i < 20; i++)
		begin
			if (i % 4 == 3)
				line = `MAIN_LINES + int'(randBits(3)) % 5;
			else
				line = int'(randBits(7)) % `FRAME_H;
			lo = int'(randBits(8)) % `FRAME_W;
			hi = int'(randBits(8)); // Past the edge about a third of the time
			wordA = randBits(16); // Ignored bits stay random
			wordA[14:8] = 7'(line);
			if (randBits(1) == 16'd1)
				wordB = {8'(hi), 8'(lo)};
			else
				wordB = {8'(lo), 8'(hi)};
			sendWord(wordA);
			sendWord(wordB);
			paintModel(wordA, wordB);
		end
		waitCleanFrame();

		// Two off-frame commands back to back, both consumed with no pixels
		wordA = randBits(16);
		wordA[14:8] = 7'(`FRAME_H + int'(randBits(3)));
		line = int'(randBits(7)) % `FRAME_H;
		wordB = {1'b0, 7'(line), 8'h07}; // Would paint a line if taken as word A
		sendWord(wordA);
		sendWord(wordB);
		paintModel(wordA, wordB);
		wordA = randBits(16);
		wordA[14:8] = 7'(`FRAME_H + int'(randBits(3)));
		wordB = {8'd0, 8'(`FRAME_W - 1)};
		sendWord(wordA);
		sendWord(wordB);
		paintModel(wordA, wordB);
		waitCleanFrame();

		// Burst with we stuck high, every word valid as A or B, long spans
		dropped = 0;
		sawFull = 1'b0;
		for (int i = 0; i < 70; i++)
		begin
			@(negedge clk);
			word = {3'b000, 5'(randBits(5)), 1'b1, 7'(randBits(7))};
			we = 1'b1;
			data = word;
			if (full)
			begin
				if (!sawFull)
				begin
					// Queue holds 63 once the first pair has been popped
					assert (accepted.size() == (2 ** `QUEUE_AW - 1) + 2) else
					begin
						$display("Fail %0t: full rose after %0d words, expected %0d",
							$time, accepted.size(), (2 ** `QUEUE_AW - 1) + 2);
						ctrlErrors++;
					end
				end
				dropped++; // Lost at the next edge
				sawFull = 1'b1;
			end
			else
				accepted.push_back(word);
		end
		if (accepted.size() % 2 == 1)
		begin
			word = {3'b000, 5'(randBits(5)), 1'b1, 7'(randBits(7))};
			sendWord(word); // Completes the last pair
			accepted.push_back(word);
		end
		for (int i = 0; i + 1 < accepted.size(); i += 2)
			paintModel(accepted[i], accepted[i + 1]);
		assert (sawFull && dropped > 0) else
		begin
			$display("Fail %0t: full never rose during the burst", $time);
			ctrlErrors++;
		end
		waitCleanFrame();

		$display("Pixel checks %0d, sync checks %0d, scan errors %0d, control errors %0d",
			pixelChecks, syncChecks, scanErrors, ctrlErrors);
		if (scanErrors == 0 && ctrlErrors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
